//--- common/eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

    localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0]  SFD_BYTE       = 8'hD5;
    localparam int          HEADER_BYTES   = 42;  // eth 14 + ipv4 20 + udp 8.

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  IP_TTL         = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;  // don't fragment.
    localparam int          IP_HDR_LEN     = 20;
    localparam int          UDP_HDR_LEN    = 8;

    localparam logic [31:0] CRC32_POLY     = 32'hEDB88320;  // reflected form.
    localparam logic [31:0] CRC32_INIT     = 32'hFFFF_FFFF;

    // fields in wire order, first byte on the wire in the msbs
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  proto;
        logic [15:0] hdr_csum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } eth_hdr_fields_t;

    typedef logic [HEADER_BYTES-1:0][7:0] eth_hdr_bytes_t;  // byte 41 goes first.

    typedef union packed {
        eth_hdr_fields_t fields;
        eth_hdr_bytes_t  bytes;
    } eth_hdr_u;

endpackage

`default_nettype wire

//--- common/mac_timing_pkg.sv
`default_nettype none

package mac_timing_pkg;

    localparam int PREAMBLE_LEN  = 7;
    localparam int SFD_LEN       = 1;
    localparam int FCS_LEN       = 4;
    localparam int IFG_LEN       = 12;

    localparam int PAYLOAD_LEN_W = 11;
    localparam int FIFO_DEPTH    = 2048;
    localparam int FIFO_ADDR_W   = 11;
    localparam int FIFO_CNT_W    = 12;  // holds 0..FIFO_DEPTH.

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        HEADER,
        DATA,
        FCS,
        GAP
    } tx_phase_e;

endpackage

`default_nettype wire

//--- hdl/crc32_gen.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_gen
    import eth_frame_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       clr_i,
    input  wire logic       en_i,
    input  wire logic [7:0] data_i,
    output logic [31:0]     crc_o
);

    logic [31:0] crc_q;

    // one byte, lsb first through the reflected polynomial
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC32_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i) begin
            crc_q <= CRC32_INIT;
        end else if (en_i) begin
            crc_q <= crc_byte(crc_q, data_i);
        end
    end

    assign crc_o = ~crc_q;

endmodule

`default_nettype wire

//--- hdl/payload_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module payload_fifo
    import mac_timing_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_i,
    input  wire logic                  wr_en_i,
    input  wire logic [7:0]            wr_data_i,
    input  wire logic                  rd_en_i,
    output logic [7:0]                 rd_data_o,
    output logic [FIFO_CNT_W-1:0]      count_o,
    output logic                       full_o
);

    logic [7:0]             mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr_q;
    logic [FIFO_ADDR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0]  count_q;
    logic                   wr_ok;
    logic                   rd_ok;

    assign full_o    = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
    assign wr_ok     = wr_en_i && !full_o;  // dropped when full.
    assign rd_ok     = rd_en_i && (count_q != '0);
    assign rd_data_o = mem[rd_ptr_q];  // head shown without latency.
    assign count_o   = count_q;

    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr_q <= wr_ptr_q + FIFO_ADDR_W'(1);
            end
            if (rd_ok) begin
                rd_ptr_q <= rd_ptr_q + FIFO_ADDR_W'(1);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count_q <= count_q + FIFO_CNT_W'(1);
                2'b01:   count_q <= count_q - FIFO_CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/udp_header_gen.sv
`timescale 1ns/1ps
`default_nettype none

module udp_header_gen
    import eth_frame_pkg::*;
    import mac_timing_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic                     start_i,
    input  wire logic [PAYLOAD_LEN_W-1:0] payload_bytes_i,
    input  wire logic [47:0]              src_mac_i,
    input  wire logic [47:0]              dst_mac_i,
    input  wire logic [31:0]              src_ip_i,
    input  wire logic [31:0]              dst_ip_i,
    input  wire logic [15:0]              src_port_i,
    input  wire logic [15:0]              dst_port_i,
    output eth_hdr_u                      header_o
);

    logic [15:0]      ident_q;
    logic [15:0]      ip_total_len;
    logic [15:0]      udp_len;
    logic [9:0][15:0] ip_words;
    logic [19:0]      ip_sum;
    logic [16:0]      sum_fold;
    logic [15:0]      ip_csum;

    assign ip_total_len = 16'(IP_HDR_LEN + UDP_HDR_LEN) + 16'(payload_bytes_i);
    assign udp_len      = 16'(UDP_HDR_LEN) + 16'(payload_bytes_i);

    // ipv4 header words with the checksum field as zero
    assign ip_words = {IP_VER_IHL, 8'h00, ip_total_len, ident_q, IP_FLAGS_DF,
                       IP_TTL, IP_PROTO_UDP, 16'h0000, src_ip_i, dst_ip_i};

    always_comb begin
        ip_sum = '0;
        for (int i = 0; i < 10; i++) begin
            ip_sum = ip_sum + 20'(ip_words[i]);
        end
        sum_fold = {1'b0, ip_sum[15:0]} + 17'(ip_sum[19:16]);
        ip_csum  = ~(sum_fold[15:0] + 16'(sum_fold[16]));  // second fold.
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ident_q <= '0;
        end else if (start_i) begin
            ident_q <= ident_q + 16'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            header_o.fields.dst_mac    <= dst_mac_i;
            header_o.fields.src_mac    <= src_mac_i;
            header_o.fields.ethertype  <= ETHERTYPE_IPV4;
            header_o.fields.ver_ihl    <= IP_VER_IHL;
            header_o.fields.tos        <= 8'h00;
            header_o.fields.total_len  <= ip_total_len;
            header_o.fields.ident      <= ident_q;
            header_o.fields.flags_frag <= IP_FLAGS_DF;
            header_o.fields.ttl        <= IP_TTL;
            header_o.fields.proto      <= IP_PROTO_UDP;
            header_o.fields.hdr_csum   <= ip_csum;
            header_o.fields.src_ip     <= src_ip_i;
            header_o.fields.dst_ip     <= dst_ip_i;
            header_o.fields.src_port   <= src_port_i;
            header_o.fields.dst_port   <= dst_port_i;
            header_o.fields.udp_len    <= udp_len;
            header_o.fields.udp_csum   <= 16'h0000;  // udp checksum unused.
        end
    end

endmodule

`default_nettype wire

//--- hdl/udp_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module udp_tx_top
    import eth_frame_pkg::*;
    import mac_timing_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic                     wr_en_i,
    input  wire logic [7:0]               wr_data_i,
    input  wire logic [PAYLOAD_LEN_W-1:0] payload_bytes_i,
    input  wire logic [47:0]              src_mac_i,
    input  wire logic [47:0]              dst_mac_i,
    input  wire logic [31:0]              src_ip_i,
    input  wire logic [31:0]              dst_ip_i,
    input  wire logic [15:0]              src_port_i,
    input  wire logic [15:0]              dst_port_i,
    output logic                          fifo_full_o,
    output logic                          tx_en_o,
    output logic [7:0]                    tx_d_o
);

    logic [7:0]               fifo_data;
    logic [FIFO_CNT_W-1:0]    fifo_count;
    logic                     fifo_rd;
    logic                     frame_start;
    logic                     cnt_load;
    logic [PAYLOAD_LEN_W-1:0] cnt_len;
    logic                     cnt_last;
    tx_phase_e                phase;
    eth_hdr_u                 header;
    logic                     crc_en;
    logic                     crc_clr;
    logic [7:0]               tx_byte;
    logic [31:0]              crc;

    payload_fifo u_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wr_en_i  (wr_en_i),
        .wr_data_i(wr_data_i),
        .rd_en_i  (fifo_rd),
        .rd_data_o(fifo_data),
        .count_o  (fifo_count),
        .full_o   (fifo_full_o)
    );

    mac_tx_fsm u_fsm (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fifo_count_i   (fifo_count),
        .payload_bytes_i(payload_bytes_i),
        .last_i         (cnt_last),
        .phase_o        (phase),
        .frame_start_o  (frame_start),
        .cnt_load_o     (cnt_load),
        .cnt_len_o      (cnt_len),
        .fifo_rd_o      (fifo_rd)
    );

    mac_tx_counter u_counter (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .load_i(cnt_load),
        .len_i (cnt_len),
        .last_o(cnt_last)
    );

    udp_header_gen u_header_gen (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (frame_start),
        .payload_bytes_i(payload_bytes_i),
        .src_mac_i      (src_mac_i),
        .dst_mac_i      (dst_mac_i),
        .src_ip_i       (src_ip_i),
        .dst_ip_i       (dst_ip_i),
        .src_port_i     (src_port_i),
        .dst_port_i     (dst_port_i),
        .header_o       (header)
    );

    mac_tx_shifter u_shifter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .phase_i    (phase),
        .header_i   (header),
        .fifo_data_i(fifo_data),
        .crc_i      (crc),
        .crc_en_o   (crc_en),
        .crc_clr_o  (crc_clr),
        .byte_o     (tx_byte),
        .tx_en_o    (tx_en_o),
        .tx_d_o     (tx_d_o)
    );

    crc32_gen u_crc (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .clr_i (crc_clr),
        .en_i  (crc_en),
        .data_i(tx_byte),
        .crc_o (crc)
    );

endmodule

`default_nettype wire

//--- mac_tx/mac_tx_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mac_tx_counter
    import mac_timing_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic                     load_i,
    input  wire logic [PAYLOAD_LEN_W-1:0] len_i,
    output logic                          last_o
);

    logic [PAYLOAD_LEN_W-1:0] cnt_q;  // cycles left in phase, incl. current.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= len_i;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - PAYLOAD_LEN_W'(1);
        end
    end

    assign last_o = (cnt_q == PAYLOAD_LEN_W'(1));

endmodule

`default_nettype wire

//--- mac_tx/mac_tx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mac_tx_fsm
    import eth_frame_pkg::*;
    import mac_timing_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic [FIFO_CNT_W-1:0]    fifo_count_i,
    input  wire logic [PAYLOAD_LEN_W-1:0] payload_bytes_i,
    input  wire logic                     last_i,
    output tx_phase_e                     phase_o,
    output logic                          frame_start_o,
    output logic                          cnt_load_o,
    output logic [PAYLOAD_LEN_W-1:0]      cnt_len_o,
    output logic                          fifo_rd_o
);

    tx_phase_e                phase_q;
    tx_phase_e                phase_next;
    logic [PAYLOAD_LEN_W-1:0] payload_len_q;

    // start once a whole payload sits in the fifo
    assign frame_start_o = (phase_q == IDLE) &&
                           (fifo_count_i >= FIFO_CNT_W'(payload_bytes_i));
    assign fifo_rd_o     = (phase_q == DATA);
    assign phase_o       = phase_q;

    always_comb begin
        phase_next = phase_q;
        cnt_load_o = 1'b0;
        cnt_len_o  = '0;
        case (phase_q)
            IDLE: begin
                if (frame_start_o) begin
                    phase_next = PREAMBLE;
                    cnt_load_o = 1'b1;
                    cnt_len_o  = PAYLOAD_LEN_W'(PREAMBLE_LEN);
                end
            end
            PREAMBLE: begin
                if (last_i) begin
                    phase_next = SFD;
                    cnt_load_o = 1'b1;
                    cnt_len_o  = PAYLOAD_LEN_W'(SFD_LEN);
                end
            end
            SFD: begin
                if (last_i) begin
                    phase_next = HEADER;
                    cnt_load_o = 1'b1;
                    cnt_len_o  = PAYLOAD_LEN_W'(HEADER_BYTES);
                end
            end
            HEADER: begin
                if (last_i) begin
                    phase_next = DATA;
                    cnt_load_o = 1'b1;
                    cnt_len_o  = payload_len_q;  // length seen at frame start.
                end
            end
            DATA: begin
                if (last_i) begin
                    phase_next = FCS;
                    cnt_load_o = 1'b1;
                    cnt_len_o  = PAYLOAD_LEN_W'(FCS_LEN);
                end
            end
            FCS: begin
                if (last_i) begin
                    phase_next = GAP;
                    cnt_load_o = 1'b1;
                    cnt_len_o  = PAYLOAD_LEN_W'(IFG_LEN);
                end
            end
            GAP: begin
                if (last_i) begin
                    phase_next = IDLE;
                end
            end
            default: phase_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase_q <= IDLE;
        end else begin
            phase_q <= phase_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (frame_start_o) begin
            payload_len_q <= payload_bytes_i;
        end
    end

endmodule

`default_nettype wire

//--- mac_tx/mac_tx_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module mac_tx_shifter
    import eth_frame_pkg::*;
    import mac_timing_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire tx_phase_e   phase_i,
    input  wire eth_hdr_u    header_i,
    input  wire logic [7:0]  fifo_data_i,
    input  wire logic [31:0] crc_i,
    output logic             crc_en_o,
    output logic             crc_clr_o,
    output logic [7:0]       byte_o,
    output logic             tx_en_o,
    output logic [7:0]       tx_d_o
);

    eth_hdr_u    hdr_sr;
    logic [23:0] fcs_sr;  // remaining fcs bytes.
    tx_phase_e   phase_q;
    logic        fcs_first;
    logic        tx_valid;

    assign fcs_first = (phase_i == FCS) && (phase_q != FCS);

    always_comb begin
        byte_o    = 8'h00;
        tx_valid  = 1'b1;
        crc_en_o  = 1'b0;
        crc_clr_o = 1'b0;
        case (phase_i)
            IDLE: begin
                tx_valid  = 1'b0;
                crc_clr_o = 1'b1;
            end
            PREAMBLE: byte_o = PREAMBLE_BYTE;
            SFD:      byte_o = SFD_BYTE;
            HEADER: begin
                byte_o   = hdr_sr.bytes[HEADER_BYTES-1];
                crc_en_o = 1'b1;
            end
            DATA: begin
                byte_o   = fifo_data_i;
                crc_en_o = 1'b1;
            end
            FCS:      byte_o = fcs_first ? crc_i[7:0] : fcs_sr[7:0];  // low byte first.
            default:  tx_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (phase_i == SFD) begin
            hdr_sr <= header_i;  // loaded just before HEADER.
        end else if (phase_i == HEADER) begin
            hdr_sr.bytes <= {hdr_sr.bytes[HEADER_BYTES-2:0], 8'h00};
        end
        if (fcs_first) begin
            fcs_sr <= crc_i[31:8];
        end else if (phase_i == FCS) begin
            fcs_sr <= {8'h00, fcs_sr[23:8]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase_q <= IDLE;
            tx_en_o <= 1'b0;
            tx_d_o  <= 8'h00;
        end else begin
            phase_q <= phase_i;
            tx_en_o <= tx_valid;
            tx_d_o  <= byte_o;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the UDP transmit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_udp_tx -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_udp_tx)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- src.f
+incdir+testbench
common/eth_frame_pkg.sv
common/mac_timing_pkg.sv
hdl/payload_fifo.sv
mac_tx/mac_tx_fsm.sv
mac_tx/mac_tx_counter.sv
mac_tx/mac_tx_shifter.sv
hdl/udp_header_gen.sv
hdl/crc32_gen.sv
hdl/udp_tx_top.sv
testbench/tb_udp_tx.sv

//--- testbench/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

typedef logic [7:0] byte_q_t [$];

// appends a field msb first, as it goes on the wire
task automatic push_field(inout byte_q_t q, input logic [47:0] value, input int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) begin
        q.push_back(value[8*i +: 8]);
    end
endtask

// ones'-complement sum over the ten ipv4 header words, folded to 16 bits
function automatic logic [15:0] ip_fold_sum(input byte_q_t h, input bit skip_csum);
    logic [31:0] sum;
    sum = 32'h0;
    for (int w = 0; w < 10; w++) begin
        if (!(skip_csum && w == 5)) begin  // word 5 is the checksum field.
            sum = sum + {16'h0, h[14 + 2*w], h[15 + 2*w]};
        end
    end
    while (sum[31:16] != 16'h0) begin
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    end
    return sum[15:0];
endfunction

function automatic logic [15:0] ip_checksum(input byte_q_t h);
    return ~ip_fold_sum(h, 1'b1);
endfunction

task automatic build_header(input int n, input logic [15:0] ident,
                            input logic [47:0] dst_mac, input logic [47:0] src_mac,
                            input logic [31:0] src_ip, input logic [31:0] dst_ip,
                            input logic [15:0] src_port, input logic [15:0] dst_port,
                            output byte_q_t hdr);
    byte_q_t     q;
    logic [15:0] csum;
    push_field(q, dst_mac, 6);
    push_field(q, src_mac, 6);
    push_field(q, 48'h0800, 2);  // ipv4 ethertype.
    push_field(q, 48'h45, 1);
    push_field(q, 48'h00, 1);
    push_field(q, 48'(28 + n), 2);
    push_field(q, 48'(ident), 2);
    push_field(q, 48'h4000, 2);  // df set, no fragments.
    push_field(q, 48'd64, 1);
    push_field(q, 48'd17, 1);
    push_field(q, 48'h0, 2);
    push_field(q, 48'(src_ip), 4);
    push_field(q, 48'(dst_ip), 4);
    push_field(q, 48'(src_port), 2);
    push_field(q, 48'(dst_port), 2);
    push_field(q, 48'(8 + n), 2);
    push_field(q, 48'h0, 2);
    csum = ip_checksum(q);
    q[24] = csum[15:8];
    q[25] = csum[7:0];
    hdr = q;
endtask

// msb-first crc-32 register, each byte fed lsb first
function automatic logic [31:0] fcs_of(input byte_q_t data);
    logic [31:0] r;
    logic [31:0] rev;
    logic        fb;
    r = 32'hFFFF_FFFF;
    foreach (data[k]) begin
        for (int b = 0; b < 8; b++) begin
            fb = r[31] ^ data[k][b];
            r = {r[30:0], 1'b0};
            if (fb) begin
                r = r ^ 32'h04C1_1DB7;
            end
        end
    end
    for (int b = 0; b < 32; b++) begin
        rev[b] = r[31-b];
    end
    return ~rev;
endfunction

`endif

//--- testbench/tb_udp_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_tx;

    localparam int NUM_FRAMES = 8;
    localparam int WAIT_LIMIT = 20000;  // cycles.
    localparam int MIN_GAP    = 12;
    localparam int FIFO_BYTES = 2048;  // payload fifo depth.

    logic        clk_i;
    logic        rst_i;
    logic        wr_en_i;
    logic [7:0]  wr_data_i;
    logic [10:0] payload_bytes_i;
    logic [47:0] src_mac_i;
    logic [47:0] dst_mac_i;
    logic [31:0] src_ip_i;
    logic [31:0] dst_ip_i;
    logic [15:0] src_port_i;
    logic [15:0] dst_port_i;
    logic        fifo_full_o;
    logic        tx_en_o;
    logic [7:0]  tx_d_o;

    `include "tb_frame_model.svh"

    int          exp_len      [NUM_FRAMES];
    logic [47:0] exp_src_mac  [NUM_FRAMES];
    logic [47:0] exp_dst_mac  [NUM_FRAMES];
    logic [31:0] exp_src_ip   [NUM_FRAMES];
    logic [31:0] exp_dst_ip   [NUM_FRAMES];
    logic [15:0] exp_src_port [NUM_FRAMES];
    logic [15:0] exp_dst_port [NUM_FRAMES];
    byte_q_t     payload_q;
    byte_q_t     burst_q;
    int          errors;
    int          frames_written;
    int          bursts_started;
    int          bursts_done;
    int          low_cnt;
    int          fifo_level;  // bytes the fifo should hold.
    logic        wr_landing;  // a write lands on the coming edge.
    logic        in_burst;
    logic        seen_burst;
    logic        aborted;

    udp_tx_top DUT (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wr_en_i        (wr_en_i),
        .wr_data_i      (wr_data_i),
        .payload_bytes_i(payload_bytes_i),
        .src_mac_i      (src_mac_i),
        .dst_mac_i      (dst_mac_i),
        .src_ip_i       (src_ip_i),
        .dst_ip_i       (dst_ip_i),
        .src_port_i     (src_port_i),
        .dst_port_i     (dst_port_i),
        .fifo_full_o    (fifo_full_o),
        .tx_en_o        (tx_en_o),
        .tx_d_o         (tx_d_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic compare_range(input string name, input int frame, input int first,
                                 input byte_q_t exp, input int exp_first, input int count);
        for (int i = 0; i < count; i++) begin
            if (burst_q[first + i] != exp[exp_first + i]) begin
                $display("FAIL %s frame %0d byte %0d: expected %02h, actual %02h", name,
                         frame, i, exp[exp_first + i], burst_q[first + i]);
                errors++;
                break;  // first mismatch only.
            end
        end
    endtask

    task automatic check_frame(input int idx);
        byte_q_t     hdr;
        byte_q_t     stream;
        byte_q_t     start_q;
        byte_q_t     cap_hdr;
        byte_q_t     fcs_q;
        logic [31:0] fcs;
        logic [15:0] csum;
        int          n;
        n = exp_len[idx];
        build_header(n, 16'(idx), exp_dst_mac[idx], exp_src_mac[idx], exp_src_ip[idx],
                     exp_dst_ip[idx], exp_src_port[idx], exp_dst_port[idx], hdr);
        stream = hdr;
        for (int i = 0; i < n; i++) begin
            stream.push_back(payload_q.pop_front());
        end
        fcs = fcs_of(stream);
        if (burst_q.size() != 54 + n) begin
            $display("FAIL frame_length frame %0d: expected %0d, actual %0d", idx, 54 + n,
                     burst_q.size());
            errors++;
            return;
        end
        for (int i = 0; i < 7; i++) begin
            start_q.push_back(8'h55);
        end
        start_q.push_back(8'hD5);
        for (int i = 0; i < 4; i++) begin
            fcs_q.push_back(fcs[8*i +: 8]);  // low byte first.
        end
        for (int i = 0; i < 42; i++) begin
            cap_hdr.push_back(burst_q[8 + i]);
        end
        compare_range("preamble_sfd", idx, 0, start_q, 0, 8);
        compare_range("header", idx, 8, hdr, 0, 42);
        csum = ip_checksum(cap_hdr);
        if (csum != {cap_hdr[24], cap_hdr[25]}) begin
            $display("FAIL ip_checksum frame %0d: expected %04h, actual %04h", idx, csum,
                     {cap_hdr[24], cap_hdr[25]});
            errors++;
        end
        if (ip_fold_sum(cap_hdr, 1'b0) != 16'hFFFF) begin
            $display("FAIL ip_sum frame %0d: expected ffff, actual %04h", idx,
                     ip_fold_sum(cap_hdr, 1'b0));
            errors++;
        end
        compare_range("payload", idx, 50, stream, 42, n);
        compare_range("fcs", idx, 50 + n, fcs_q, 0, 4);
    endtask

    task automatic start_burst();
        if (seen_burst && low_cnt < MIN_GAP) begin
            $display("FAIL spacing frame %0d: expected >= %0d idle cycles, actual %0d",
                     bursts_started, MIN_GAP, low_cnt);
            errors++;
        end
        if (bursts_started >= NUM_FRAMES) begin
            $display("ERROR: a burst appeared with no frame queued");
            errors++;
        end else if (frames_written <= bursts_started) begin
            $display("ERROR: frame %0d started before its payload was fully written",
                     bursts_started);
            errors++;
        end
        burst_q.delete();
        in_burst   = 1'b1;
        seen_burst = 1'b1;
        bursts_started++;
    endtask

    // burst capture on the falling edge, where gmii outputs are settled
    initial begin
        int pos;
        forever begin
            @(negedge clk_i);
            if (rst_i) begin
                low_cnt    = 0;
                fifo_level = 0;
                wr_landing = 1'b0;
            end else begin
                if (wr_landing) begin
                    fifo_level++;
                end
                if (tx_en_o === 1'b1) begin
                    if (!in_burst) begin
                        start_burst();
                    end
                    pos = burst_q.size();
                    if (bursts_started <= NUM_FRAMES && pos >= 50 &&
                        pos < 50 + exp_len[bursts_started - 1]) begin
                        fifo_level--;  // popped on the edge that launched it.
                    end
                    burst_q.push_back(tx_d_o);
                end else if (in_burst) begin
                    in_burst = 1'b0;
                    if (bursts_done < NUM_FRAMES) begin
                        check_frame(bursts_done);
                    end
                    bursts_done++;
                    low_cnt = 1;
                end else begin
                    low_cnt++;
                end
                if (fifo_full_o !== (fifo_level == FIFO_BYTES)) begin
                    $display("FAIL fifo_full level %0d: expected %b, actual %b", fifo_level,
                             fifo_level == FIFO_BYTES, fifo_full_o);
                    errors++;
                end
                wr_landing = wr_en_i && (fifo_level < FIFO_BYTES);
            end
        end
    end

    task automatic wait_for_burst(input int idx);
        int waited;
        waited = 0;
        while (bursts_started < idx && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (bursts_started < idx) begin
            $display("ERROR: frame %0d never started on the wire", idx - 1);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic send_frame(input int idx);
        logic [7:0] b;
        int         waited;
        exp_len[idx]      = 18 + int'($urandom % 1455);
        exp_src_mac[idx]  = {16'($urandom), $urandom};
        exp_dst_mac[idx]  = {16'($urandom), $urandom};
        exp_src_ip[idx]   = $urandom;
        exp_dst_ip[idx]   = $urandom;
        exp_src_port[idx] = 16'($urandom);
        exp_dst_port[idx] = 16'($urandom);
        @(posedge clk_i);
        payload_bytes_i <= 11'(exp_len[idx]);
        src_mac_i       <= exp_src_mac[idx];
        dst_mac_i       <= exp_dst_mac[idx];
        src_ip_i        <= exp_src_ip[idx];
        dst_ip_i        <= exp_dst_ip[idx];
        src_port_i      <= exp_src_port[idx];
        dst_port_i      <= exp_dst_port[idx];
        for (int i = 0; i < exp_len[idx]; i++) begin
            if (($urandom % 8) == 0) begin
                @(posedge clk_i);
                wr_en_i <= 1'b0;  // random pause.
            end
            b = 8'($urandom);
            @(posedge clk_i);
            wr_en_i   <= 1'b1;
            wr_data_i <= b;
            // held until a low full flag lets it land on the next edge
            @(negedge clk_i);
            waited = 0;
            while (fifo_full_o && waited < WAIT_LIMIT) begin
                @(negedge clk_i);
                waited++;
            end
            if (fifo_full_o) begin
                $display("ERROR: payload FIFO stayed full while writing frame %0d", idx);
                errors++;
                aborted = 1'b1;
                return;
            end
            payload_q.push_back(b);
        end
        @(posedge clk_i);
        wr_en_i <= 1'b0;
        frames_written++;
    endtask

    initial begin
        int i;
        int waited;
        errors          = 0;
        frames_written  = 0;
        bursts_started  = 0;
        bursts_done     = 0;
        low_cnt         = 0;
        fifo_level      = 0;
        wr_landing      = 1'b0;
        in_burst        = 1'b0;
        seen_burst      = 1'b0;
        aborted         = 1'b0;
        rst_i           = 1'b1;
        wr_en_i         = 1'b0;
        wr_data_i       = 8'h00;
        payload_bytes_i = 11'd18;  // nonzero so an empty fifo never starts a frame.
        src_mac_i       = 48'h0;
        dst_mac_i       = 48'h0;
        src_ip_i        = 32'h0;
        dst_ip_i        = 32'h0;
        src_port_i      = 16'h0;
        dst_port_i      = 16'h0;
        void'($urandom(80));
        for (i = 0; i < 4; i++) begin
            @(negedge clk_i);
            if (tx_en_o !== 1'b0) begin
                $display("FAIL reset_tx_en: expected 0, actual %b", tx_en_o);
                errors++;
            end
        end
        @(posedge clk_i);
        rst_i <= 1'b0;
        for (i = 0; i < 20; i++) begin
            @(negedge clk_i);
            if (tx_en_o !== 1'b0) begin
                $display("FAIL idle_tx_en: expected 0, actual %b", tx_en_o);
                errors++;
            end
        end
        for (i = 0; i < NUM_FRAMES && !aborted; i++) begin
            if (i > 0) begin
                wait_for_burst(i);  // next payload goes in while this frame is sent.
            end
            if (!aborted) begin
                send_frame(i);
            end
        end
        waited = 0;
        while (!aborted && bursts_done < NUM_FRAMES && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!aborted && bursts_done < NUM_FRAMES) begin
            $display("ERROR: only %0d of %0d frames finished before the timeout",
                     bursts_done, NUM_FRAMES);
            errors++;
        end
        if (!aborted) begin
            repeat (40) @(negedge clk_i);
        end
        if (payload_q.size() != 0) begin
            $display("ERROR: %0d written payload bytes were never sent", payload_q.size());
            errors++;
        end
        $display("frames checked: %0d, errors: %0d", bursts_done, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
